// ==== apbPkg.sv ====
// APB3 subset with 12-bit byte addresses, 32-bit data and no PPROT or PSTRB signals
`default_nettype none

package apbPkg;

    // Register byte address within the peripheral window
    typedef logic [11:0] apbAddr_t;

    // Bus data word
    typedef logic [31:0] apbData_t;

    // Requester side of the bus, driven by the interconnect
    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    // Completer side of the bus
    typedef struct packed {
        apbData_t prdata;
        logic     pready;
        logic     pslverr;
    } apbRsp_t;

    // Register map, word aligned
    localparam apbAddr_t AddrTxData = 12'h000;
    localparam apbAddr_t AddrStatus = 12'h004;
    localparam apbAddr_t AddrCtrl   = 12'h008;

endpackage

`default_nettype wire

// ==== uartPkg.sv ====
// UART transmit types for 8 data bits, optional even parity and one or two stop bits
`default_nettype none

package uartPkg;

    // One character on the line
    typedef logic [7:0] uartByte_t;

    // Start bit, eight data bits and the parity slot
    // Stop bits come from the one-fill of the shifter
    localparam int FrameBits = 10;
    typedef logic [FrameBits-1:0] uartFrame_t;

    // Index of the data bit being sent
    typedef logic [2:0] uartBitIdx_t;

    // Sequencer states, one per frame section
    typedef enum logic [2:0] {
        Idle   = 3'd0,
        Load   = 3'd1,
        Start  = 3'd2,
        Data   = 3'd3,
        Parity = 3'd4,
        Stop   = 3'd5
    } txState_t;

    // CTRL register, bit 0 is enable
    typedef struct packed {
        logic twoStop;
        logic parityEn;
        logic enable;
    } uartCtrl_t;

    // STATUS register, bit 0 is idle, bit 2 is the sticky overflow
    typedef struct packed {
        logic overflow;
        logic full;
        logic idle;
    } uartStatus_t;

endpackage

`default_nettype wire

// ==== uartApbRegs.sv ====
// Zero wait state APB completer; TXDATA reads return zero and only bits 2:0 of CTRL exist
`timescale 1ns/1ps
`default_nettype none

module uartApbRegs (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire apbPkg::apbReq_t  req,
    output apbPkg::apbRsp_t       rsp,
    input  wire logic             fifoFull,
    input  wire logic             txIdle,
    output logic                  push,
    output uartPkg::uartByte_t    pushData,
    output uartPkg::uartCtrl_t    ctrl
);

    logic access;
    logic wrAccess;
    logic hitTxData;
    logic hitStatus;
    logic hitCtrl;
    logic addrValid;
    logic overflow;
    uartPkg::uartStatus_t status;

    // Access phase of a transfer, the only cycle with any effect
    assign access   = req.psel && req.penable;
    assign wrAccess = access && req.pwrite;

    assign hitTxData = (req.paddr == apbPkg::AddrTxData);
    assign hitStatus = (req.paddr == apbPkg::AddrStatus);
    assign hitCtrl   = (req.paddr == apbPkg::AddrCtrl);
    assign addrValid = hitTxData || hitStatus || hitCtrl;

    // Byte goes straight to the FIFO in the access cycle
    assign push     = wrAccess && hitTxData && !fifoFull;
    assign pushData = req.pwdata[7:0];

    always_comb begin
        status.idle     = txIdle;
        status.full     = fifoFull;
        status.overflow = overflow;
    end

    // Read mux, zero outside a valid read
    always_comb begin
        rsp.pready  = 1'b1;
        rsp.pslverr = access && !addrValid;
        rsp.prdata  = '0;
        if (access && !req.pwrite) begin
            if (hitStatus) begin
                rsp.prdata = apbPkg::apbData_t'(status);
            end
            else if (hitCtrl) begin
                rsp.prdata = apbPkg::apbData_t'(ctrl);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl     <= '0;
            overflow <= 1'b0;
        end
        else begin
            if (wrAccess && hitCtrl) begin
                ctrl <= uartPkg::uartCtrl_t'(req.pwdata[2:0]);
            end
            // Dropped byte wins over a clear in the same cycle
            if (wrAccess && hitTxData && fifoFull) begin
                overflow <= 1'b1;
            end
            else if (wrAccess && hitStatus && req.pwdata[2]) begin
                overflow <= 1'b0;
            end
        end
    end

    // Each TXDATA write pushes for one cycle only
    pushOneCycle: assert property (@(posedge clk) disable iff (rst) push |=> !push)
        else $error("push held for more than one cycle");

endmodule

`default_nettype wire

// ==== uartTxFifo.sv ====
// FifoDepth must be a power of two and at least 2; head is registered and valid the cycle after pop
`timescale 1ns/1ps
`default_nettype none

module uartTxFifo #(
    parameter int FifoDepth = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                push,
    input  wire uartPkg::uartByte_t  pushData,
    input  wire logic                pop,
    output uartPkg::uartByte_t       head,
    output logic                     full,
    output logic                     empty
);

    localparam int PtrBits = $clog2(FifoDepth);

    typedef logic [PtrBits-1:0] fifoPtr_t;
    typedef logic [PtrBits:0]   fifoCount_t;

    uartPkg::uartByte_t mem [FifoDepth];
    fifoPtr_t   wrPtr;
    fifoPtr_t   rdPtr;
    fifoCount_t count;

    assign full  = (count == fifoCount_t'(FifoDepth));
    assign empty = (count == '0);

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end
            else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage and read register
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
        if (pop) begin
            head <= mem[rdPtr];
        end
    end

    noPopEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("FIFO pop while empty");
    noPushFull: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("FIFO push while full");

endmodule

`default_nettype wire

// ==== uartBaudTimer.sv ====
// Fixed bit period of ClocksPerBit clocks, at least 2; no fractional baud adjustment
`timescale 1ns/1ps
`default_nettype none

module uartBaudTimer #(
    parameter int ClocksPerBit = 16
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic run,
    output logic      bitTick
);

    localparam int CountBits = $clog2(ClocksPerBit + 1);

    typedef logic [CountBits-1:0] baudCount_t;

    localparam baudCount_t LastCount = baudCount_t'(ClocksPerBit - 1);

    baudCount_t count;

    // Last clock of the current bit period
    assign bitTick = run && (count == LastCount);

    always_ff @(posedge clk) begin
        if (rst || start) begin
            count <= '0;
        end
        else if (run) begin
            count <= (count == LastCount) ? '0 : count + 1'b1;
        end
        else begin
            count <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== uartTxSequencer.sv ====
// Reads CTRL live, so parity and stop settings should only change while the transmitter is idle
`timescale 1ns/1ps
`default_nettype none

module uartTxSequencer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire uartPkg::uartCtrl_t  ctrl,
    input  wire logic                fifoEmpty,
    input  wire logic                bitTick,
    output logic                     pop,
    output logic                     start,
    output logic                     run,
    output logic                     advance,
    output logic                     idle
);

    uartPkg::txState_t   state;
    uartPkg::uartBitIdx_t bitCount;
    logic                secondStop;

    always_comb begin
        pop     = (state == uartPkg::Idle) && ctrl.enable && !fifoEmpty;
        start   = (state == uartPkg::Load);
        run     = (state != uartPkg::Idle) && (state != uartPkg::Load);
        // Timer only ticks while a frame runs
        advance = bitTick;
        // Nothing on the line and nothing waiting
        idle    = (state == uartPkg::Idle) && fifoEmpty;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= uartPkg::Idle;
            bitCount   <= '0;
            secondStop <= 1'b0;
        end
        else begin
            unique case (state)
                uartPkg::Idle: begin
                    if (pop) begin
                        state <= uartPkg::Load;
                    end
                end
                uartPkg::Load: begin
                    state      <= uartPkg::Start;
                    bitCount   <= '0;
                    secondStop <= 1'b0;
                end
                uartPkg::Start: begin
                    if (bitTick) begin
                        state <= uartPkg::Data;
                    end
                end
                uartPkg::Data: begin
                    if (bitTick) begin
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7) begin
                            state <= ctrl.parityEn ? uartPkg::Parity : uartPkg::Stop;
                        end
                    end
                end
                uartPkg::Parity: begin
                    if (bitTick) begin
                        state <= uartPkg::Stop;
                    end
                end
                uartPkg::Stop: begin
                    // Extra period for the second stop bit
                    if (bitTick) begin
                        if (ctrl.twoStop && !secondStop) begin
                            secondStop <= 1'b1;
                        end
                        else begin
                            state <= uartPkg::Idle;
                        end
                    end
                end
                default: state <= uartPkg::Idle;
            endcase
        end
    end

    noAdvanceIdle: assert property (@(posedge clk) disable iff (rst)
        advance |-> (state != uartPkg::Idle))
        else $error("advance while sequencer idle");

endmodule

`default_nettype wire

// ==== uartTxShifter.sv ====
// Even parity only; the stop bits and idle level come from the one-fill of the shift
`timescale 1ns/1ps
`default_nettype none

module uartTxShifter (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                load,
    input  wire uartPkg::uartByte_t  loadData,
    input  wire logic                advance,
    input  wire logic                parityEn,
    output logic                     txLine
);

    uartPkg::uartFrame_t frame;
    logic                parityBit;

    // Even parity, or a plain stop level in that slot
    assign parityBit = parityEn ? ^loadData : 1'b1;

    // LSB of the frame is the current line level
    assign txLine = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            frame <= '1;
        end
        else if (load) begin
            // Parity slot, data LSB first, start bit low
            frame <= {parityBit, loadData, 1'b0};
        end
        else if (advance) begin
            frame <= {1'b1, frame[uartPkg::FrameBits-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== uartTxTop.sv ====
// Transmit-only UART on APB with a fixed bit period; no receiver, interrupts or flow control
`timescale 1ns/1ps
`default_nettype none

module uartTxTop #(
    parameter int ClocksPerBit = 16,
    parameter int FifoDepth    = 4
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire apbPkg::apbReq_t  req,
    output apbPkg::apbRsp_t       rsp,
    output logic                  txLine
);

    logic               push;
    uartPkg::uartByte_t pushData;
    uartPkg::uartCtrl_t ctrl;
    uartPkg::uartByte_t head;
    logic               fifoFull;
    logic               fifoEmpty;
    logic               pop;
    logic               start;
    logic               run;
    logic               bitTick;
    logic               advance;
    logic               txIdle;

    uartApbRegs regs (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rsp      (rsp),
        .fifoFull (fifoFull),
        .txIdle   (txIdle),
        .push     (push),
        .pushData (pushData),
        .ctrl     (ctrl)
    );

    uartTxFifo #(
        .FifoDepth (FifoDepth)
    ) fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .head     (head),
        .full     (fifoFull),
        .empty    (fifoEmpty)
    );

    uartBaudTimer #(
        .ClocksPerBit (ClocksPerBit)
    ) timer (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .run     (run),
        .bitTick (bitTick)
    );

    uartTxSequencer sequencer (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .fifoEmpty (fifoEmpty),
        .bitTick   (bitTick),
        .pop       (pop),
        .start     (start),
        .run       (run),
        .advance   (advance),
        .idle      (txIdle)
    );

    // Head byte is valid in Load, one cycle after the pop
    uartTxShifter shifter (
        .clk      (clk),
        .rst      (rst),
        .load     (start),
        .loadData (head),
        .advance  (advance),
        .parityEn (ctrl.parityEn),
        .txLine   (txLine)
    );

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
// Free-running clock from time zero; reset is released 1 ns after the last reset edge
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int Period      = 8,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Synchronous reset held over the first rising edges
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== uartTxTb.sv ====
// Runs uartTxGolden.mem from the working directory; the line decoder assumes CTRL changes between frames
`timescale 1ns/1ps
`default_nettype none

module uartTxTb;

    localparam int ClocksPerBit = 8;
    localparam int FifoDepth    = 4;
    localparam int GoldenWords  = 256;
    localparam int unsigned Seed = 18;

    // Operation codes of the golden file
    localparam logic [31:0] OpEnd   = 32'h0;
    localparam logic [31:0] OpWrite = 32'h1;
    localparam logic [31:0] OpRead  = 32'h2;
    localparam logic [31:0] OpFrame = 32'h3;
    localparam logic [31:0] OpIdle  = 32'h4;

    // One frame as seen on the line
    typedef struct packed {
        logic [7:0] data;
        logic       parity;
        logic       hasParity;
    } rxFrame_t;

    logic               clk;
    logic               rst;
    apbPkg::apbReq_t    req;
    apbPkg::apbRsp_t    rsp;
    logic               txLine;

    logic [31:0]        golden [GoldenWords];
    rxFrame_t           rxQueue [$];
    uartPkg::uartCtrl_t shadowCtrl;
    logic               decoderBusy;
    logic               lastLevel;
    logic               limitReady;
    int unsigned        lcgState;
    int unsigned        cycleCount;
    int unsigned        cycleLimit;
    int                 errorCount;
    int                 testErrors;
    int                 testsRun;
    int                 testsFailed;

    tbClockGen #(
        .Period      (8),
        .ResetCycles (2)
    ) clockGen (
        .clk (clk),
        .rst (rst)
    );

    uartTxTop #(
        .ClocksPerBit (ClocksPerBit),
        .FifoDepth    (FifoDepth)
    ) dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rsp    (rsp),
        .txLine (txLine)
    );

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        // Low bits of an LCG repeat quickly
        return lcgState >> 16;
    endfunction

    function automatic string testName(input logic [31:0] num);
        case (num)
            1: return "reset state";
            2: return "8N1 frames";
            3: return "parity and two stops";
            4: return "ordering";
            5: return "overflow";
            6: return "bad address";
            default: return "unnamed";
        endcase
    endfunction

    task automatic randomGap();
        int unsigned gap;
        gap = nextRand() % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Setup then access phase; starts and ends 1 ns after a rising edge
    task automatic busTransfer(input logic write, input apbPkg::apbAddr_t addr,
                               input apbPkg::apbData_t wdata,
                               output apbPkg::apbData_t rdata, output logic slverr);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk);
        #1;
        req.penable = 1'b1;
        // Response settled by mid-cycle
        @(negedge clk);
        rdata  = rsp.prdata;
        slverr = rsp.pslverr;
        assert (rsp.pready === 1'b1) else begin
            errorCount++;
            $display("ERR pready @%h exp 1 got %h", addr, rsp.pready);
        end
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic writeReg(input apbPkg::apbAddr_t addr, input logic [31:0] data,
                            input logic expErr);
        apbPkg::apbData_t rdata;
        logic             slverr;
        busTransfer(1'b1, addr, data, rdata, slverr);
        assert (slverr === expErr) else begin
            errorCount++;
            $display("ERR pslverr @%h exp %h got %h", addr, expErr, slverr);
        end
        if (addr == apbPkg::AddrCtrl && !expErr) begin
            shadowCtrl = uartPkg::uartCtrl_t'(data[2:0]);
        end
        randomGap();
    endtask

    task automatic checkRead(input apbPkg::apbAddr_t addr, input logic [31:0] expData,
                             input logic expErr);
        apbPkg::apbData_t rdata;
        logic             slverr;
        busTransfer(1'b0, addr, '0, rdata, slverr);
        assert (rdata === expData) else begin
            errorCount++;
            $display("ERR prdata @%h exp %h got %h", addr, expData, rdata);
        end
        assert (slverr === expErr) else begin
            errorCount++;
            $display("ERR pslverr @%h exp %h got %h", addr, expErr, slverr);
        end
        randomGap();
    endtask

    task automatic expectFrame(input logic [7:0] expByte);
        rxFrame_t frame;
        while (rxQueue.size() == 0) begin
            @(posedge clk);
            #1;
        end
        frame = rxQueue.pop_front();
        assert (frame.data === expByte) else begin
            errorCount++;
            $display("ERR txLine data exp %h got %h", expByte, frame.data);
        end
        // Even parity: ninth bit is the XOR of the data bits
        if (frame.hasParity) begin
            assert (frame.parity === ^expByte) else begin
                errorCount++;
                $display("ERR txLine parity exp %h got %h", ^expByte, frame.parity);
            end
        end
    endtask

    task automatic idleCycles(input logic [31:0] cycles, input logic checkQuiet);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        if (checkQuiet) begin
            assert (rxQueue.size() == 0 && !decoderBusy) else begin
                errorCount++;
                $display("A frame appeared on the line where none was expected");
            end
            assert (txLine === 1'b1) else begin
                errorCount++;
                $display("ERR txLine exp 1 got %h", txLine);
            end
        end
    endtask

    task automatic closeTest(input logic [31:0] num);
        int newErrors;
        newErrors = errorCount - testErrors;
        testsRun++;
        if (newErrors == 0) begin
            $display("Test %0d (%s): pass", num, testName(num));
        end
        else begin
            testsFailed++;
            $display("Test %0d (%s): fail with %0d errors", num, testName(num), newErrors);
        end
        testErrors = errorCount;
    endtask

    // Samples on eight falling edges starting with the current one
    task automatic sampleBit(input int bitIdx, output logic level);
        logic [ClocksPerBit-1:0] samples;
        for (int i = 0; i < ClocksPerBit; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            samples[i] = txLine;
        end
        level = samples[ClocksPerBit/2 - 1];
        assert (samples === {ClocksPerBit{level}}) else begin
            errorCount++;
            $display("Frame bit %0d did not hold for %0d cycles", bitIdx, ClocksPerBit);
        end
    endtask

    task automatic receiveFrame();
        rxFrame_t frame;
        logic     level;
        int       stopBits;
        int       bitIdx;
        frame           = '0;
        frame.hasParity = shadowCtrl.parityEn;
        stopBits        = shadowCtrl.twoStop ? 2 : 1;
        decoderBusy     = 1'b1;
        sampleBit(0, level);
        assert (level === 1'b0) else begin
            errorCount++;
            $display("ERR txLine start exp 0 got %h", level);
        end
        // Data LSB first
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            sampleBit(i + 1, level);
            frame.data[i] = level;
        end
        bitIdx = 9;
        if (frame.hasParity) begin
            @(negedge clk);
            sampleBit(bitIdx, level);
            frame.parity = level;
            bitIdx++;
        end
        for (int i = 0; i < stopBits; i++) begin
            @(negedge clk);
            sampleBit(bitIdx + i, level);
            assert (level === 1'b1) else begin
                errorCount++;
                $display("ERR txLine stop exp 1 got %h", level);
            end
        end
        rxQueue.push_back(frame);
        decoderBusy = 1'b0;
    endtask

    // Worst case of 12 bit periods per frame
    task automatic loadGolden();
        int unsigned total;
        logic [31:0] op;
        total = 0;
        $readmemh("uartTxGolden.mem", golden);
        for (int i = 0; i < GoldenWords; i += 4) begin
            op = golden[i];
            if (op == OpWrite || op == OpRead) begin
                total += 6;
            end
            else if (op == OpFrame) begin
                total += 12 * ClocksPerBit + 3;
            end
            else if (op == OpIdle) begin
                total += golden[i + 2];
            end
        end
        cycleLimit = total + total / 2 + 16;
        limitReady = 1'b1;
    endtask

    task automatic runGolden();
        logic [31:0]      op;
        apbPkg::apbAddr_t addr;
        logic [31:0]      data;
        logic             flag;
        logic             done;
        int               idx;
        done = 1'b0;
        idx  = 0;
        while (!done) begin
            if (idx >= GoldenWords) begin
                errorCount++;
                $display("Golden file ends without a final end line");
                done = 1'b1;
            end
            else begin
                op   = golden[idx];
                addr = golden[idx + 1][11:0];
                data = golden[idx + 2];
                flag = golden[idx + 3][0];
                idx += 4;
                case (op)
                    OpWrite: writeReg(addr, data, flag);
                    OpRead:  checkRead(addr, data, flag);
                    OpFrame: expectFrame(data[7:0]);
                    OpIdle:  idleCycles(data, flag);
                    OpEnd: begin
                        closeTest(data);
                        done = flag;
                    end
                    default: begin
                        errorCount++;
                        $display("Unknown operation code %h at operation %0d", op, idx / 4);
                        done = 1'b1;
                    end
                endcase
            end
        end
    endtask

    // Line decoder, watches for a falling edge between frames
    initial begin
        decoderBusy = 1'b0;
        lastLevel   = 1'b1;
        forever begin
            @(negedge clk);
            if (!rst && lastLevel === 1'b1 && txLine === 1'b0) begin
                receiveFrame();
            end
            lastLevel = txLine;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycleCount <= 0;
        end
        else begin
            cycleCount <= cycleCount + 1;
        end
    end

    initial begin
        wait (limitReady === 1'b1);
        wait (cycleCount >= cycleLimit);
        $display("Timeout: run stopped after %0d cycles", cycleCount);
        $display("Test failed");
        $finish;
    end

    initial begin
        req         = '0;
        shadowCtrl  = '0;
        lcgState    = Seed;
        errorCount  = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        limitReady  = 1'b0;
        loadGolden();
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        runGolden();
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && testsRun > 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uartTxGolden.mem ====
// Columns: op addr data flag (hex); op 1 write, 2 read-check, 3 expect-frame, 4 idle, 0 end
// flag: expected pslverr for ops 1 and 2, quiet line check for 4, last test for 0
// Test 1, reset state
2 004 00000001 0
2 008 00000000 0
4 000 00000004 1
0 000 00000001 0
// Test 2, 8N1 frames
1 008 00000001 0
1 000 000000A5 0
3 000 000000A5 0
1 000 0000003C 0
3 000 0000003C 0
0 000 00000002 0
// Test 3, even parity and two stop bits
1 008 00000007 0
2 008 00000007 0
1 000 0000005A 0
3 000 0000005A 0
1 000 00000007 0
3 000 00000007 0
0 000 00000003 0
// Test 4, four bytes back to back
1 008 00000001 0
1 000 00000011 0
1 000 00000022 0
1 000 00000033 0
1 000 00000044 0
3 000 00000011 0
3 000 00000022 0
3 000 00000033 0
3 000 00000044 0
2 004 00000001 0
0 000 00000004 0
// Test 5, fifth write overflows while disabled
1 008 00000000 0
1 000 00000061 0
1 000 00000062 0
1 000 00000063 0
1 000 00000064 0
1 000 00000065 0
2 004 00000006 0
1 008 00000001 0
3 000 00000061 0
3 000 00000062 0
3 000 00000063 0
3 000 00000064 0
4 000 00000028 1
2 004 00000005 0
1 004 00000004 0
2 004 00000001 0
0 000 00000005 0
// Test 6, unmapped address
2 00C 00000000 1
1 00C FFFFFFFF 1
2 008 00000001 0
2 004 00000001 0
0 000 00000006 1

// ==== build.f ====
apbPkg.sv
uartPkg.sv
uartApbRegs.sv
uartTxFifo.sv
uartBaudTimer.sv
uartTxSequencer.sv
uartTxShifter.sv
uartTxTop.sv
tbClockGen.sv
uartTxTb.sv

// ==== Makefile ====
# Verilator build and run of the APB UART transmitter testbench

VERILATOR ?= verilator
TOP       ?= uartTxTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
